// File: Makefile
SIM_DIR := obj_dir
SIM_BIN := $(SIM_DIR)/Vtb_axi4_w_buffer
SOURCES := $(shell grep -v '^+' axi4_w_buffer.f)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): axi4_w_buffer.f $(SOURCES)
	verilator --binary --timing --assert -j 0 \
	  --top-module tb_axi4_w_buffer \
	  --Mdir $(SIM_DIR) \
	  -f axi4_w_buffer.f

# The log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf $(SIM_DIR) sim.log

// File: axi4_w_buffer.f
common/w_beat_pkg.sv
common/w_decision_pkg.sv
common/w_beat_if.sv
verilog/w_stream_fifo.sv
verilog/w_decision_queue.sv
w_burst_steer/w_burst_steer.sv
verilog/axi4_w_buffer.sv
verification/tb_axi4_w_buffer.sv

// File: common/w_beat_if.sv
`timescale 1ns/1ps
`default_nettype none

// Valid/ready W-beat link between the input buffer and the burst steer
interface w_beat_if;
  import w_beat_pkg::*;

  logic [AXI_DATA_WIDTH-1:0] wdata;
  logic [AXI_STRB_WIDTH-1:0] wstrb;
  logic                      wlast;
  logic [AXI_USER_WIDTH-1:0] wuser;
  logic                      wvalid;
  logic                      wready;

  // Beat source, holds the beat while wvalid is high and wready is low
  modport sender (
    output wdata, wstrb, wlast, wuser, wvalid,
    input  wready
  );

  // Beat sink
  modport receiver (
    input  wdata, wstrb, wlast, wuser, wvalid,
    output wready
  );

endinterface

`default_nettype wire

// File: common/w_beat_pkg.sv
`default_nettype none

// Widths and record type of one AXI4 W-channel beat
package w_beat_pkg;

  localparam int AXI_DATA_WIDTH = 32;
  // One strobe bit per data byte
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
  localparam int AXI_USER_WIDTH = 4;

  // Beat as stored in the input buffer
  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic                      last;
    logic [AXI_USER_WIDTH-1:0] user;
  } w_beat_t;

endpackage

`default_nettype wire

// File: common/w_decision_pkg.sv
`default_nettype none

// Translation decisions from the L1 TLB and the queue depths
package w_decision_pkg;

  localparam int AXI_ID_WIDTH = 4;

  // W beats held ahead of the steering logic
  localparam int INPUT_BUFFER_DEPTH   = 4;
  // Decisions that may run ahead of their W data
  localparam int DECISION_QUEUE_DEPTH = 8;

  // One decision, in write-address order
  typedef struct packed {
    logic                    prefetch;
    logic                    hit;
    logic [AXI_ID_WIDTH-1:0] id;
    logic                    master;
    logic                    accept;
    logic                    drop;
  } l1_decision_t;

endpackage

`default_nettype wire

// File: verification/tb_axi4_w_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi4_w_buffer;
  import w_beat_pkg::*;
  import w_decision_pkg::*;

  // Expected master beat, tagged with the master flag of its burst
  typedef struct packed {
    logic    master;
    w_beat_t beat;
  } fwd_t;

  logic                      axi4_aclk;
  logic                      axi4_arstn = 1'b1;
  logic                      l1_accept_i, l1_drop_i, l1_master_i;
  logic [AXI_ID_WIDTH-1:0]   l1_id_i;
  logic                      l1_prefetch_i, l1_hit_i, l1_done_o;
  logic                      input_stall_o, master_select_o;
  logic                      b_drop_o, b_done_i, prefetch_o, hit_o;
  logic [AXI_ID_WIDTH-1:0]   id_o;
  logic [AXI_DATA_WIDTH-1:0] s_axi4_wdata_i, m_axi4_wdata_o;
  logic [AXI_STRB_WIDTH-1:0] s_axi4_wstrb_i, m_axi4_wstrb_o;
  logic [AXI_USER_WIDTH-1:0] s_axi4_wuser_i, m_axi4_wuser_o;
  logic                      s_axi4_wlast_i, s_axi4_wvalid_i, s_axi4_wready_o;
  logic                      m_axi4_wlast_o, m_axi4_wvalid_o, m_axi4_wready_i;
  logic [41:0]               m_seen;

  // Model state
  fwd_t         exp_fwd[$];
  logic [5:0]   exp_drop[$];
  l1_decision_t dec_q[$];
  w_beat_t      beat_q[$];
  fwd_t         fwd_front;
  logic [5:0]   drop_front;
  logic         fwd_valid = 1'b0;
  logic         drop_valid = 1'b0;
  logic         bp_mode = 1'b0;
  int           dec_count = 0;
  int           errors = 0;
  int           errors_at_start = 0;
  int           passed = 0;
  int           failed = 0;
  int unsigned  budget = 200;
  int unsigned  lcg_state = 32'd59;

  axi4_w_buffer u_dut (.*);

  assign m_seen = {master_select_o, m_axi4_wdata_o, m_axi4_wstrb_o, m_axi4_wlast_o,
                   m_axi4_wuser_o};

  initial begin
    axi4_aclk = 1'b0;
    forever #4 axi4_aclk = ~axi4_aclk;
  end

  a_reset: assert property (@(posedge axi4_aclk) !axi4_arstn |->
    !m_axi4_wvalid_o && !b_drop_o && !l1_done_o && s_axi4_wready_o)
    else begin
      errors++;
      $display("Mismatch at %0t: outputs not in reset state", $time);
    end
  a_forward: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    m_axi4_wvalid_o && m_axi4_wready_i |-> fwd_valid && m_seen == fwd_front)
    else begin
      errors++;
      $display("Mismatch at %0t: master beat %h, expected %h", $time,
               $sampled(m_seen), $sampled(fwd_front));
    end
  a_hold: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    $past(m_axi4_wvalid_o && !m_axi4_wready_i) |-> m_axi4_wvalid_o && m_seen == $past(m_seen))
    else begin
      errors++;
      $display("Mismatch at %0t: stalled master beat changed to %h", $time, $sampled(m_seen));
    end
  a_drop_rise: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    $rose(b_drop_o) |-> drop_valid && {id_o, prefetch_o, hit_o} == drop_front)
    else begin
      errors++;
      $display("Mismatch at %0t: drop request %h, expected %h", $time,
               $sampled({id_o, prefetch_o, hit_o}), $sampled(drop_front));
    end
  a_drop_hold: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    $past(b_drop_o) |-> b_drop_o == !$past(b_done_i))
    else begin
      errors++;
      $display("Mismatch at %0t: b_drop_o is %b after b_done_i", $time, $sampled(b_drop_o));
    end
  a_stall: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    input_stall_o == (dec_count == DECISION_QUEUE_DEPTH) && !(input_stall_o && l1_done_o))
    else begin
      errors++;
      $display("Mismatch at %0t: stall %b done %b with %0d queued decisions", $time,
               $sampled(input_stall_o), $sampled(l1_done_o), $sampled(dec_count));
    end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // Upper bits are the better ones
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic void refresh_expect();
    fwd_valid  = (exp_fwd.size() != 0);
    drop_valid = (exp_drop.size() != 0);
    if (fwd_valid) begin
      fwd_front = exp_fwd[0];
    end
    if (drop_valid) begin
      drop_front = exp_drop[0];
    end
  endfunction

  function automatic void add_burst(input logic accept, input int unsigned len);
    l1_decision_t d;
    w_beat_t      b;
    int unsigned  r;
    r          = lcg_next();
    d.accept   = accept;
    d.drop     = !accept;
    d.master   = r[3];
    d.prefetch = r[5];
    d.hit      = r[7];
    d.id       = r[11:8];
    dec_q.push_back(d);
    if (!accept) begin
      exp_drop.push_back({d.id, d.prefetch, d.hit});
    end
    for (int unsigned i = 0; i < len; i++) begin
      b.data = lcg_next();
      r      = lcg_next();
      b.strb = r[3:0];
      b.user = r[7:4];
      b.last = (i == len - 1);
      beat_q.push_back(b);
      if (accept) begin
        exp_fwd.push_back({d.master, b});
      end
    end
    budget += len * 20;
    refresh_expect();
  endfunction

  // Follows the DUT handshakes and retires model entries
  task automatic track_outputs();
    logic done_seen;
    logic fwd_seen;
    logic last_seen;
    logic b_seen;
    forever begin
      // Handshake signals are stable away from the rising edge
      @(negedge axi4_aclk);
      done_seen = l1_done_o;
      fwd_seen  = m_axi4_wvalid_o && m_axi4_wready_i;
      last_seen = m_axi4_wlast_o;
      b_seen    = b_drop_o && b_done_i;
      @(posedge axi4_aclk);
      if (done_seen) begin
        dec_count++;
      end
      if (fwd_seen && exp_fwd.size() != 0) begin
        void'(exp_fwd.pop_front());
        if (last_seen) begin
          dec_count--;
        end
      end
      if (b_seen) begin
        if (exp_drop.size() != 0) begin
          void'(exp_drop.pop_front());
        end
        dec_count--;
      end
      refresh_expect();
    end
  endtask

  task automatic answer_b_sender();
    int unsigned r;
    forever begin
      @(negedge axi4_aclk);
      if (b_drop_o && !b_done_i) begin
        r = lcg_next();
        repeat (r % 4) @(posedge axi4_aclk);
        @(posedge axi4_aclk);
        b_done_i <= 1'b1;
        @(posedge axi4_aclk);
        b_done_i <= 1'b0;
      end
    end
  endtask

  task automatic drive_master_ready();
    int unsigned r;
    forever begin
      @(posedge axi4_aclk);
      r = lcg_next();
      m_axi4_wready_i <= !bp_mode || (r % 3 != 0);
    end
  endtask

  task automatic drive_decisions();
    l1_decision_t d;
    logic         taken;
    while (dec_q.size() != 0) begin
      d = dec_q.pop_front();
      l1_accept_i   <= d.accept;
      l1_drop_i     <= d.drop;
      l1_master_i   <= d.master;
      l1_id_i       <= d.id;
      l1_prefetch_i <= d.prefetch;
      l1_hit_i      <= d.hit;
      // TLB holds the request until done
      do begin
        @(negedge axi4_aclk);
        taken = l1_done_o;
        @(posedge axi4_aclk);
      end while (!taken);
    end
    l1_accept_i <= 1'b0;
    l1_drop_i   <= 1'b0;
  endtask

  task automatic drive_beats(input logic hold_beats);
    w_beat_t     b;
    int unsigned r;
    logic        taken;
    if (hold_beats) begin
      while (!input_stall_o) @(negedge axi4_aclk);
      repeat (5) @(posedge axi4_aclk);
    end
    while (beat_q.size() != 0) begin
      r = lcg_next();
      if (r % 4 == 0) begin
        s_axi4_wvalid_i <= 1'b0;
        @(posedge axi4_aclk);
      end
      b = beat_q.pop_front();
      s_axi4_wdata_i  <= b.data;
      s_axi4_wstrb_i  <= b.strb;
      s_axi4_wlast_i  <= b.last;
      s_axi4_wuser_i  <= b.user;
      s_axi4_wvalid_i <= 1'b1;
      do begin
        @(negedge axi4_aclk);
        taken = s_axi4_wready_o;
        @(posedge axi4_aclk);
      end while (!taken);
    end
    s_axi4_wvalid_i <= 1'b0;
  endtask

  task automatic run_traffic(input logic hold_beats);
    @(posedge axi4_aclk);
    fork
      drive_decisions();
      drive_beats(hold_beats);
    join
    while (exp_fwd.size() != 0 || exp_drop.size() != 0 || b_drop_o) @(negedge axi4_aclk);
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      passed++;
      $display("Test %s: ok", name);
    end else begin
      failed++;
      $display("Test %s: failed with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    int unsigned r;
    axi4_arstn      <= 1'b0;
    {l1_accept_i, l1_drop_i, l1_master_i, l1_prefetch_i, l1_hit_i} <= '0;
    l1_id_i         <= '0;
    b_done_i        <= 1'b0;
    s_axi4_wdata_i  <= '0;
    s_axi4_wstrb_i  <= '0;
    s_axi4_wlast_i  <= 1'b0;
    s_axi4_wuser_i  <= '0;
    s_axi4_wvalid_i <= 1'b0;
    m_axi4_wready_i <= 1'b1;
    repeat (10) @(posedge axi4_aclk);
    axi4_arstn <= 1'b1;
    fork
      track_outputs();
      answer_b_sender();
      drive_master_ready();
    join_none
    repeat (3) @(posedge axi4_aclk);
    finish_test("reset");
    for (int i = 0; i < 4; i++) add_burst(1'b1, 1 + lcg_next() % 8);
    run_traffic(1'b0);
    finish_test("accepted bursts");
    for (int i = 0; i < 3; i++) add_burst(1'b0, 1 + lcg_next() % 8);
    run_traffic(1'b0);
    finish_test("dropped bursts");
    bp_mode = 1'b1;
    for (int i = 0; i < 6; i++) add_burst(i != 2, 1 + lcg_next() % 8);
    run_traffic(1'b0);
    bp_mode = 1'b0;
    finish_test("back-pressure");
    // One decision more than the queue holds
    for (int i = 0; i <= DECISION_QUEUE_DEPTH; i++) add_burst(1'b1, 2);
    run_traffic(1'b1);
    finish_test("full queue");
    for (int i = 0; i < 12; i++) begin
      r = lcg_next();
      add_burst(r[1], 1 + lcg_next() % 8);
    end
    run_traffic(1'b0);
    finish_test("mixed sequence");
    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Budget grows with every queued beat
  initial begin
    int unsigned cycles;
    cycles = 0;
    while (cycles <= budget) begin
      @(posedge axi4_aclk);
      cycles++;
    end
    $display("Timeout: the DUT stopped making progress after %0d cycles", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/axi4_w_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// W-data buffer of the address-translating AXI4 bridge, L1 TLB path
module axi4_w_buffer (
  input  logic                                     axi4_aclk,
  input  logic                                     axi4_arstn,

  // L1 TLB decisions
  input  logic                                     l1_accept_i,
  input  logic                                     l1_drop_i,
  input  logic                                     l1_master_i,
  input  logic [w_decision_pkg::AXI_ID_WIDTH-1:0]  l1_id_i,
  input  logic                                     l1_prefetch_i,
  input  logic                                     l1_hit_i,
  output logic                                     l1_done_o,

  output logic                                     input_stall_o,
  output logic                                     master_select_o,

  // B sender
  output logic                                     b_drop_o,
  input  logic                                     b_done_i,
  output logic [w_decision_pkg::AXI_ID_WIDTH-1:0]  id_o,
  output logic                                     prefetch_o,
  output logic                                     hit_o,

  // Slave W channel
  input  logic [w_beat_pkg::AXI_DATA_WIDTH-1:0]    s_axi4_wdata_i,
  input  logic [w_beat_pkg::AXI_STRB_WIDTH-1:0]    s_axi4_wstrb_i,
  input  logic                                     s_axi4_wlast_i,
  input  logic [w_beat_pkg::AXI_USER_WIDTH-1:0]    s_axi4_wuser_i,
  input  logic                                     s_axi4_wvalid_i,
  output logic                                     s_axi4_wready_o,

  // Master W channel
  output logic [w_beat_pkg::AXI_DATA_WIDTH-1:0]    m_axi4_wdata_o,
  output logic [w_beat_pkg::AXI_STRB_WIDTH-1:0]    m_axi4_wstrb_o,
  output logic                                     m_axi4_wlast_o,
  output logic [w_beat_pkg::AXI_USER_WIDTH-1:0]    m_axi4_wuser_o,
  output logic                                     m_axi4_wvalid_o,
  input  logic                                     m_axi4_wready_i
);
  import w_beat_pkg::*;
  import w_decision_pkg::*;

  w_beat_t      s_beat;
  w_beat_t      buf_beat;
  l1_decision_t l1_decision;
  l1_decision_t head;
  logic         head_valid;
  logic         head_pop;

  w_beat_if in_beats ();

  assign s_beat.data = s_axi4_wdata_i;
  assign s_beat.strb = s_axi4_wstrb_i;
  assign s_beat.last = s_axi4_wlast_i;
  assign s_beat.user = s_axi4_wuser_i;

  w_stream_fifo #(
    .payload_t (w_beat_t),
    .DEPTH     (INPUT_BUFFER_DEPTH)
  ) u_input_buf (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .data_i     (s_beat),
    .valid_i    (s_axi4_wvalid_i),
    .ready_o    (s_axi4_wready_o),
    .data_o     (buf_beat),
    .valid_o    (in_beats.wvalid),
    .ready_i    (in_beats.wready),
    .full_o     ()
  );

  // Buffer head onto the beat link
  assign in_beats.wdata = buf_beat.data;
  assign in_beats.wstrb = buf_beat.strb;
  assign in_beats.wlast = buf_beat.last;
  assign in_beats.wuser = buf_beat.user;

  assign l1_decision.prefetch = l1_prefetch_i;
  assign l1_decision.hit      = l1_hit_i;
  assign l1_decision.id       = l1_id_i;
  assign l1_decision.master   = l1_master_i;
  assign l1_decision.accept   = l1_accept_i;
  assign l1_decision.drop     = l1_drop_i;

  w_decision_queue u_decision_queue (
    .axi4_aclk     (axi4_aclk),
    .axi4_arstn    (axi4_arstn),
    .l1_decision_i (l1_decision),
    .l1_done_o     (l1_done_o),
    .input_stall_o (input_stall_o),
    .head_o        (head),
    .head_valid_o  (head_valid),
    .pop_i         (head_pop)
  );

  w_burst_steer u_burst_steer (
    .axi4_aclk       (axi4_aclk),
    .axi4_arstn      (axi4_arstn),
    .in_beats        (in_beats),
    .head_i          (head),
    .head_valid_i    (head_valid),
    .pop_o           (head_pop),
    .m_wdata_o       (m_axi4_wdata_o),
    .m_wstrb_o       (m_axi4_wstrb_o),
    .m_wlast_o       (m_axi4_wlast_o),
    .m_wuser_o       (m_axi4_wuser_o),
    .m_wvalid_o      (m_axi4_wvalid_o),
    .m_wready_i      (m_axi4_wready_i),
    .master_select_o (master_select_o),
    .b_drop_o        (b_drop_o),
    .b_done_i        (b_done_i)
  );

  // B sender always sees the head decision
  assign id_o       = head.id;
  assign prefetch_o = head.prefetch;
  assign hit_o      = head.hit;

endmodule

`default_nettype wire

// File: verilog/w_decision_queue.sv
`timescale 1ns/1ps
`default_nettype none

// Queue of L1 TLB decisions, oldest write address at the head
module w_decision_queue (
  input  logic                         axi4_aclk,
  input  logic                         axi4_arstn,
  // Request from the L1 TLB, held until done
  input  w_decision_pkg::l1_decision_t l1_decision_i,
  output logic                         l1_done_o,
  output logic                         input_stall_o,
  // Head decision toward the burst steer
  output w_decision_pkg::l1_decision_t head_o,
  output logic                         head_valid_o,
  input  logic                         pop_i
);
  import w_decision_pkg::*;

  logic l1_req;
  logic push;
  logic fifo_ready;
  logic fifo_full;

  // Every decision either accepts or drops its burst
  assign l1_req = l1_decision_i.accept | l1_decision_i.drop;

  // Taken only with room in the queue
  assign push = l1_req & fifo_ready;

  // Done in the same cycle as the push
  assign l1_done_o = push;

  // AW side of the TLB holds off while no decision fits
  assign input_stall_o = fifo_full;

  w_stream_fifo #(
    .payload_t (l1_decision_t),
    .DEPTH     (DECISION_QUEUE_DEPTH)
  ) u_decision_fifo (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .data_i     (l1_decision_i),
    .valid_i    (push),
    .ready_o    (fifo_ready),
    .data_o     (head_o),
    .valid_o    (head_valid_o),
    .ready_i    (pop_i),
    .full_o     (fifo_full)
  );

endmodule

`default_nettype wire

// File: verilog/w_stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// Circular valid/ready FIFO, payload given as a type parameter
module w_stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     axi4_aclk,
  input  logic     axi4_arstn,
  // Push side
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  // Pop side
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i,
  output logic     full_o
);

  payload_t                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       push;
  logic                       pop;

  assign full_o  = (int'(count) == DEPTH);
  assign ready_o = ~full_o;
  assign valid_o = (count != '0);
  assign data_o  = mem[rd_ptr];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Storage only, the occupancy count tells which entries are live
  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop in one cycle leave the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: w_burst_steer/w_burst_steer.sv
`timescale 1ns/1ps
`default_nettype none

// Forwards or discards the burst at the head of the input buffer,
// following the decision at the head of the queue
module w_burst_steer (
  input  logic                                     axi4_aclk,
  input  logic                                     axi4_arstn,
  // Beats from the input buffer
  w_beat_if.receiver                               in_beats,
  // Head decision
  input  w_decision_pkg::l1_decision_t             head_i,
  input  logic                                     head_valid_i,
  output logic                                     pop_o,
  // Master W port
  output logic [w_beat_pkg::AXI_DATA_WIDTH-1:0]    m_wdata_o,
  output logic [w_beat_pkg::AXI_STRB_WIDTH-1:0]    m_wstrb_o,
  output logic                                     m_wlast_o,
  output logic [w_beat_pkg::AXI_USER_WIDTH-1:0]    m_wuser_o,
  output logic                                     m_wvalid_o,
  input  logic                                     m_wready_i,
  output logic                                     master_select_o,
  // B sender handshake
  output logic                                     b_drop_o,
  input  logic                                     b_done_i
);

  logic w_done;
  logic b_drop_set;

  // Drop request to the B sender, held until it confirms
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      b_drop_o <= 1'b0;
    end else if (b_done_i) begin
      b_drop_o <= 1'b0;
    end else if (b_drop_set) begin
      b_drop_o <= 1'b1;
    end
  end

  always_comb begin
    w_done          = 1'b0;
    b_drop_set      = 1'b0;
    in_beats.wready = 1'b0;

    // Idle master port shows zero data
    m_wdata_o  = '0;
    m_wstrb_o  = '0;
    m_wlast_o  = 1'b0;
    m_wuser_o  = '0;
    m_wvalid_o = 1'b0;

    if (head_valid_i) begin
      if (head_i.accept) begin
        // Pass the buffer head straight through
        m_wdata_o       = in_beats.wdata;
        m_wstrb_o       = in_beats.wstrb;
        m_wlast_o       = in_beats.wlast;
        m_wuser_o       = in_beats.wuser;
        m_wvalid_o      = in_beats.wvalid;
        in_beats.wready = m_wready_i;
        w_done          = in_beats.wvalid & in_beats.wlast & m_wready_i;
      end else if (head_i.drop && !b_drop_o) begin
        // Swallow one beat per cycle, next burst waits for the B sender
        in_beats.wready = 1'b1;
        b_drop_set      = in_beats.wvalid & in_beats.wlast;
      end
    end
  end

  // Decision leaves on the last forwarded beat or on the B sender confirm
  assign pop_o = w_done | (b_drop_o & b_done_i);

  assign master_select_o = head_i.master;

endmodule

`default_nettype wire
